//--- logic/xgmii_tx_macros.svh
// XGMII transmit constants
`ifndef XGMII_TX_MACROS_SVH
`define XGMII_TX_MACROS_SVH

`default_nettype none

// XGMII control characters
`define XGMII_IDLE 8'h07
`define XGMII_START 8'hfb
`define XGMII_TERM 8'hfd
`define XGMII_ERROR 8'hfe

// preamble byte and start frame delimiter
`define ETH_PRE 8'h55
`define ETH_SFD 8'hd5

// reflected form of 32'h04c11db7
`define ETH_CRC_POLY 32'hedb88320

// frame length includes the FCS
`define MIN_FRAME_LEN 64
`define MIN_IFG_BYTES 12

`default_nettype wire

`endif

//--- logic/xgmii_tx_pkg.sv
// XGMII transmit types
`default_nettype none

package xgmii_tx_pkg;

    // one input beat, byte masked by tkeep
    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;
        logic        tvalid;
        logic        tlast;
        logic        tuser;
    } axis_beat_t;

    // lane 0 is the first character on the wire
    typedef union packed {
        logic [63:0]     raw;
        logic [7:0][7:0] lane;
    } xgmii_lane_u;

    typedef struct packed {
        xgmii_lane_u d;
        logic [7:0]  c;
    } xgmii_bus_t;

    typedef enum logic [2:0] {
        state_idle,
        state_payload,
        state_pad,
        state_fcs_1,
        state_fcs_2,
        state_err,
        state_ifg
    } tx_state_e;

    typedef enum logic [2:0] {
        sel_idle,
        sel_start,
        sel_data,
        sel_fcs_first,
        sel_fcs_second,
        sel_error
    } word_sel_e;

    typedef logic [31:0] crc_t;

endpackage

`default_nettype wire

//--- logic/xgmii_tx_ctrl.sv
// XGMII transmit frame FSM
`include "xgmii_tx_macros.svh"
`default_nettype none

module xgmii_tx_ctrl
    import xgmii_tx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_crc,
    input  wire axis_beat_t s_axis,
    input  wire logic [2:0] held_empty,
    input  wire logic       more_pad,
    input  wire logic [3:0] ifg_offset,
    input  wire logic [7:0] cfg_tx_ifg,
    input  wire logic       cfg_tx_enable,
    output logic            s_tready,
    output logic            beat_load,
    output logic            pad_fill,
    output logic            frame_begin,
    output logic            crc_restart,
    output logic            crc_update,
    output word_sel_e       word_sel
);

    tx_state_e  state;
    tx_state_e  state_next;
    logic       in_frame;
    logic       in_frame_next;
    logic       frame_err;
    logic       frame_err_next;
    logic [7:0] ifg_cnt;
    logic [7:0] ifg_cnt_next;
    logic [7:0] ifg_min;
    logic       tready_next;
    logic       accept;
    logic       end_frame;

    assign accept = s_axis.tvalid && s_tready;

    // never below the standard gap
    assign ifg_min = (cfg_tx_ifg > 8'(`MIN_IFG_BYTES)) ? cfg_tx_ifg : 8'(`MIN_IFG_BYTES);

    always_comb begin
        in_frame_next = accept ? !s_axis.tlast : in_frame;
        state_next = state;
        frame_err_next = frame_err;
        ifg_cnt_next = ifg_cnt;
        // keep draining while the source is mid frame
        tready_next = in_frame_next;
        beat_load = 1'b0;
        pad_fill = 1'b0;
        frame_begin = 1'b0;
        crc_restart = 1'b0;
        crc_update = 1'b0;
        word_sel = sel_idle;
        end_frame = 1'b0;

        case (state)
            state_idle: begin
                tready_next = cfg_tx_enable;
                frame_err_next = 1'b0;
                if (accept) begin
                    beat_load = 1'b1;
                    frame_begin = 1'b1;
                    crc_restart = 1'b1;
                    word_sel = sel_start;
                    tready_next = 1'b1;
                    state_next = state_payload;
                    // single beat frame
                    end_frame = s_axis.tlast;
                end
            end
            state_payload: begin
                tready_next = 1'b1;
                beat_load = 1'b1;
                crc_update = 1'b1;
                word_sel = sel_data;
                end_frame = !s_axis.tvalid || s_axis.tlast;
            end
            state_pad: begin
                pad_fill = 1'b1;
                crc_update = 1'b1;
                word_sel = sel_data;
                if (!more_pad) begin
                    state_next = frame_err ? state_err : state_fcs_1;
                end
            end
            state_fcs_1: begin
                word_sel = sel_fcs_first;
                ifg_cnt_next = ifg_min - 8'(ifg_offset);
                state_next = (held_empty > 3'd4) ? state_ifg : state_fcs_2;
            end
            state_fcs_2: begin
                word_sel = sel_fcs_second;
                state_next = state_ifg;
            end
            state_err: begin
                word_sel = sel_error;
                ifg_cnt_next = ifg_min - 8'(ifg_offset);
                state_next = state_ifg;
            end
            state_ifg: begin
                ifg_cnt_next = (ifg_cnt > 8'd8) ? ifg_cnt - 8'd8 : 8'd0;
                if (ifg_cnt_next == 8'd0 && !in_frame_next) begin
                    tready_next = cfg_tx_enable;
                    state_next = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase

        // source ended the frame, normally or not
        if (end_frame) begin
            tready_next = in_frame_next;
            frame_err_next = !s_axis.tvalid || s_axis.tuser;
            if (more_pad) begin
                state_next = state_pad;
            end else if (frame_err_next) begin
                state_next = state_err;
            end else begin
                state_next = state_fcs_1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= state_idle;
            in_frame <= 1'b0;
            frame_err <= 1'b0;
            ifg_cnt <= 8'd0;
            s_tready <= 1'b0;
        end else begin
            state <= state_next;
            in_frame <= in_frame_next;
            frame_err <= frame_err_next;
            ifg_cnt <= ifg_cnt_next;
            s_tready <= tready_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/tx_beat_stage.sv
// transmit beat holding stage
`include "xgmii_tx_macros.svh"
`default_nettype none

module tx_beat_stage
    import xgmii_tx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_crc,
    input  wire axis_beat_t s_axis,
    input  wire logic       beat_load,
    input  wire logic       pad_fill,
    input  wire logic       frame_begin,
    output logic [63:0]     held_data,
    output logic [2:0]      held_empty,
    output logic            more_pad
);

    // bytes owed before the FCS, counted ahead of the first beat
    localparam int PAD_START = `MIN_FRAME_LEN - 4;

    logic [5:0]  pad_cnt;
    logic [5:0]  pad_cur;
    logic [63:0] data_masked;
    logic [2:0]  empty_in;
    logic [2:0]  empty_lim;

    function automatic logic [2:0] keep_to_empty(input logic [7:0] keep);
        casez (keep)
            8'b11111111: return 3'd0;
            8'b01111111: return 3'd1;
            8'bz0111111: return 3'd2;
            8'bzz011111: return 3'd3;
            8'bzzz01111: return 3'd4;
            8'bzzzz0111: return 3'd5;
            8'bzzzzz011: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    assign pad_cur = frame_begin ? 6'(PAD_START) : pad_cnt;
    assign more_pad = pad_cur > 6'd8;
    assign empty_in = pad_fill ? 3'd7 : keep_to_empty(s_axis.tkeep);

    always_comb begin
        // lane 0 always carries data
        for (int n = 0; n < 8; n++) begin
            if (s_axis.tvalid && (n == 0 || s_axis.tkeep[n])) begin
                data_masked[8*n +: 8] = s_axis.tdata[8*n +: 8];
            end else begin
                data_masked[8*n +: 8] = 8'd0;
            end
        end
    end

    // short frames keep every byte up to the minimum
    always_comb begin
        empty_lim = empty_in;
        if (pad_cur > 6'd8) begin
            empty_lim = 3'd0;
        end else if (pad_cur != 6'd0 && 6'(empty_in) > 6'd8 - pad_cur) begin
            empty_lim = 3'(6'd8 - pad_cur);
        end
    end

    always_ff @(posedge clk) begin
        if (beat_load || pad_fill) begin
            held_data <= pad_fill ? 64'd0 : data_masked;
            held_empty <= empty_lim;
        end
        if (reset_crc) begin
            pad_cnt <= 6'd0;
        end else if (beat_load || pad_fill) begin
            pad_cnt <= more_pad ? pad_cur - 6'd8 : 6'd0;
        end
    end

endmodule

`default_nettype wire

//--- logic/eth_crc32.sv
// Ethernet CRC-32 over the held beat
`include "xgmii_tx_macros.svh"
`default_nettype none

module eth_crc32
    import xgmii_tx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_crc,
    input  wire logic [63:0] held_data,
    input  wire logic        crc_restart,
    input  wire logic        crc_update,
    output crc_t [7:0]       crc_part
);

    crc_t crc_reg;

    // one byte, LSB first
    function automatic crc_t crc_byte(input crc_t crc_in, input logic [7:0] data);
        crc_t c;
        c = crc_in ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // part n covers bytes 0 to n of the held word
    always_comb begin
        crc_t acc;
        acc = crc_reg;
        for (int n = 0; n < 8; n++) begin
            acc = crc_byte(acc, held_data[8*n +: 8]);
            crc_part[n] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_reg <= '1;
        end else if (crc_update) begin
            crc_reg <= crc_part[7];
        end
    end

endmodule

`default_nettype wire

//--- logic/xgmii_encode.sv
// XGMII word encoder
`include "xgmii_tx_macros.svh"
`default_nettype none

module xgmii_encode
    import xgmii_tx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_crc,
    input  wire word_sel_e   word_sel,
    input  wire logic [63:0] held_data,
    input  wire logic [2:0]  held_empty,
    input  wire crc_t [7:0]  crc_part,
    output xgmii_bus_t       xgmii,
    output logic [3:0]       ifg_offset
);

    xgmii_bus_t word_next;
    crc_t       fcs_next;

    // held beat and CRC stay put across both FCS words
    assign fcs_next = ~crc_part[3'd7 - held_empty];

    // idle bytes from the terminate on, in the last word
    assign ifg_offset = (word_sel == sel_error) ? 4'd1 :
                        (held_empty > 3'd4) ? 4'(held_empty) - 4'd4 : 4'(held_empty) + 4'd4;

    always_comb begin
        int data_len;
        int pos;
        data_len = 8 - int'(held_empty);
        pos = 0;
        word_next.d.raw = {8{`XGMII_IDLE}};
        word_next.c = 8'hff;
        case (word_sel)
            sel_start: begin
                word_next.d.raw = {`ETH_SFD, {6{`ETH_PRE}}, `XGMII_START};
                word_next.c = 8'h01;
            end
            sel_data: begin
                word_next.d.raw = held_data;
                word_next.c = 8'h00;
            end
            sel_fcs_first, sel_fcs_second: begin
                // data, then FCS, then terminate, then idle
                for (int i = 0; i < 8; i++) begin
                    pos = (word_sel == sel_fcs_second) ? i + 8 : i;
                    if (pos < data_len) begin
                        word_next.d.lane[i] = held_data[8*i +: 8];
                        word_next.c[i] = 1'b0;
                    end else if (pos < data_len + 4) begin
                        word_next.d.lane[i] = fcs_next[8*(pos-data_len) +: 8];
                        word_next.c[i] = 1'b0;
                    end else if (pos == data_len + 4) begin
                        word_next.d.lane[i] = `XGMII_TERM;
                    end
                end
            end
            sel_error: begin
                word_next.d.raw = {`XGMII_TERM, {7{`XGMII_ERROR}}};
            end
            default: begin
                word_next.c = 8'hff;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            xgmii.d.raw <= {8{`XGMII_IDLE}};
            xgmii.c <= 8'hff;
        end else begin
            xgmii <= word_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/xgmii_tx.sv
// 64-bit XGMII frame transmitter
`default_nettype none

module xgmii_tx
    import xgmii_tx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_crc,
    input  wire axis_beat_t s_axis,
    output logic            s_tready,
    output xgmii_bus_t      xgmii,
    input  wire logic [7:0] cfg_tx_ifg,
    input  wire logic       cfg_tx_enable
);

    logic        beat_load;
    logic        pad_fill;
    logic        frame_begin;
    logic        crc_restart;
    logic        crc_update;
    word_sel_e   word_sel;
    logic [63:0] held_data;
    logic [2:0]  held_empty;
    logic        more_pad;
    logic [3:0]  ifg_offset;
    crc_t [7:0]  crc_part;

    xgmii_tx_ctrl xgmii_tx_ctrl_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_axis(s_axis),
        .held_empty(held_empty),
        .more_pad(more_pad),
        .ifg_offset(ifg_offset),
        .cfg_tx_ifg(cfg_tx_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .s_tready(s_tready),
        .beat_load(beat_load),
        .pad_fill(pad_fill),
        .frame_begin(frame_begin),
        .crc_restart(crc_restart),
        .crc_update(crc_update),
        .word_sel(word_sel)
    );

    tx_beat_stage tx_beat_stage_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_axis(s_axis),
        .beat_load(beat_load),
        .pad_fill(pad_fill),
        .frame_begin(frame_begin),
        .held_data(held_data),
        .held_empty(held_empty),
        .more_pad(more_pad)
    );

    eth_crc32 eth_crc32_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .held_data(held_data),
        .crc_restart(crc_restart),
        .crc_update(crc_update),
        .crc_part(crc_part)
    );

    xgmii_encode xgmii_encode_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .word_sel(word_sel),
        .held_data(held_data),
        .held_empty(held_empty),
        .crc_part(crc_part),
        .xgmii(xgmii),
        .ifg_offset(ifg_offset)
    );

endmodule

`default_nettype wire

//--- verification/xgmii_tx_model.svh
// expected XGMII stream model
`ifndef XGMII_TX_MODEL_SVH
`define XGMII_TX_MODEL_SVH

// bitwise CRC-32, LSB of each byte first
function automatic crc_t model_fcs(input int len);
    crc_t c;
    c = 32'hffffffff;
    for (int i = 0; i < len; i++) begin
        for (int b = 0; b < 8; b++) begin
            if (c[0] ^ frame_buf[i][b]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
    end
    return ~c;
endfunction

task automatic put_char(input logic [7:0] ch, input logic ctl);
    char_buf[n_chars] = ch;
    ctl_buf[n_chars] = ctl;
    n_chars++;
endtask

// idle fill after the terminate, then split into words
task automatic flush_words();
    xgmii_bus_t w;
    while (n_chars % 8 != 0) begin
        put_char(`XGMII_IDLE, 1'b1);
    end
    for (int i = 0; i < n_chars; i += 8) begin
        for (int j = 0; j < 8; j++) begin
            w.d.lane[j] = char_buf[i+j];
            w.c[j] = ctl_buf[i+j];
        end
        exp_q.push_back(w);
    end
    n_chars = 0;
endtask

// cut < 0 is a good frame, else words kept before the error word
task automatic expect_frame(input int len, input int cut);
    int plen;
    crc_t fcs;
    plen = (len < `MIN_FRAME_LEN - 4) ? `MIN_FRAME_LEN - 4 : len;
    for (int i = len; i < plen; i++) begin
        frame_buf[i] = 8'd0;
    end
    n_chars = 0;
    put_char(`XGMII_START, 1'b1);
    repeat (6) put_char(`ETH_PRE, 1'b0);
    put_char(`ETH_SFD, 1'b0);
    if (cut < 0) begin
        fcs = model_fcs(plen);
        for (int i = 0; i < plen; i++) begin
            put_char(frame_buf[i], 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            put_char(fcs[8*i +: 8], 1'b0);
        end
        put_char(`XGMII_TERM, 1'b1);
    end else begin
        for (int i = 0; i < 8 * cut; i++) begin
            put_char(frame_buf[i], 1'b0);
        end
        repeat (7) put_char(`XGMII_ERROR, 1'b1);
        put_char(`XGMII_TERM, 1'b1);
    end
    flush_words();
endtask

`endif

//--- verification/xgmii_tx_tb.sv
// XGMII transmitter testbench
`include "xgmii_tx_macros.svh"
`default_nettype none

module xgmii_tx_tb
    import xgmii_tx_pkg::*;
;

    localparam int TOTAL_FRAMES = 32;
    localparam int MAX_FRAME_WORDS = 27;
    localparam int MAX_GAP_WORDS = 34;
    localparam int CYCLE_LIMIT = TOTAL_FRAMES * (MAX_FRAME_WORDS + MAX_GAP_WORDS + 8) + 100;

    logic       clk;
    logic       reset_crc;
    axis_beat_t s_axis;
    logic       s_tready;
    xgmii_bus_t xgmii;
    logic [7:0] cfg_tx_ifg;
    logic       cfg_tx_enable;

    logic [31:0] lfsr_state;
    logic [7:0]  frame_buf [0:255];
    logic [7:0]  char_buf [0:511];
    logic        ctl_buf [0:511];
    int          n_chars;
    xgmii_bus_t  exp_q [$];
    int          errors;
    int          checks;
    int          tests;
    int          cycle_cnt;
    logic        gap_on;
    int          gap_cnt;
    int          gap_req;

    xgmii_tx xgmii_tx_inst (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_axis(s_axis),
        .s_tready(s_tready),
        .xgmii(xgmii),
        .cfg_tx_ifg(cfg_tx_ifg),
        .cfg_tx_enable(cfg_tx_enable)
    );

    always #5 clk = !clk;

    `include "xgmii_tx_model.svh"

    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + rand_bits(16) % (hi - lo + 1);
    endfunction

    function automatic xgmii_bus_t idle_bus();
        xgmii_bus_t w;
        w.d.raw = {8{`XGMII_IDLE}};
        w.c = 8'hff;
        return w;
    endfunction

    task automatic check_word(input xgmii_bus_t got, input xgmii_bus_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h/%h expected %h/%h", $time, what,
                     got.d.raw, got.c, exp.d.raw, exp.c);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // gap bytes from a terminate up to the next start
    task automatic scan_gap(input xgmii_bus_t w);
        for (int i = 0; i < 8; i++) begin
            if (w.c[i] && w.d.lane[i] == `XGMII_START) begin
                if (gap_on) begin
                    check_level(gap_cnt >= gap_req, 1'b1, "interframe gap length");
                end
                gap_on = 1'b0;
            end else if (w.c[i] && w.d.lane[i] == `XGMII_TERM) begin
                // the terminate itself is the first byte of the gap
                gap_on = 1'b1;
                gap_cnt = 1;
                gap_req = (cfg_tx_ifg > `MIN_IFG_BYTES) ? cfg_tx_ifg : `MIN_IFG_BYTES;
            end else if (w.c[i] && w.d.lane[i] == `XGMII_IDLE && gap_on) begin
                gap_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset_crc) begin
            if (xgmii !== idle_bus()) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: unexpected word %h/%h", $time, xgmii.d.raw, xgmii.c);
                end else begin
                    check_word(xgmii, exp_q.pop_front(), "frame word");
                end
            end
            scan_gap(xgmii);
        end
    end

    task automatic send_beat(input axis_beat_t b, input logic drain);
        logic waiting;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge clk);
            if (drain) begin
                check_level(s_tready, 1'b1, "tready while draining");
            end
            s_axis = b;
            waiting = !s_tready;
        end
    endtask

    // gap_at is the beat index preceded by a tvalid hole, -1 for none
    task automatic run_frame(input int len, input logic bad_last, input int gap_at);
        int beats;
        int idx;
        axis_beat_t b;
        beats = (len + 7) / 8;
        for (int i = 0; i < len; i++) begin
            frame_buf[i] = 8'(rand_bits(8));
        end
        expect_frame(len, bad_last ? beats - 1 : gap_at);
        for (int k = 0; k < beats; k++) begin
            if (k == gap_at) begin
                @(negedge clk);
                s_axis.tvalid = 1'b0;
            end
            for (int j = 0; j < 8; j++) begin
                idx = k * 8 + j;
                b.tkeep[j] = idx < len;
                b.tdata[8*j +: 8] = (idx < len) ? frame_buf[idx] : 8'(rand_bits(8));
            end
            b.tvalid = 1'b1;
            b.tlast = k == beats - 1;
            b.tuser = bad_last && b.tlast;
            send_beat(b, gap_at >= 0 && k >= gap_at);
        end
        @(negedge clk);
        s_axis.tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    task automatic disabled_check();
        @(negedge clk);
        cfg_tx_enable = 1'b0;
        repeat (2) @(negedge clk);
        s_axis.tdata = 64'(rand_bits(32));
        s_axis.tkeep = 8'hff;
        s_axis.tlast = 1'b1;
        s_axis.tvalid = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_level(s_tready, 1'b0, "tready while disabled");
            check_word(xgmii, idle_bus(), "idle while disabled");
        end
        s_axis.tvalid = 1'b0;
        @(negedge clk);
        cfg_tx_enable = 1'b1;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run passed %0d cycles with %0d words still expected",
                 CYCLE_LIMIT, exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int e0;
        int len;
        clk = 1'b0;
        reset_crc = 1'b1;
        s_axis = '0;
        cfg_tx_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        lfsr_state = 32'h1155;
        n_chars = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        gap_on = 1'b0;
        gap_cnt = 0;
        gap_req = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;

        e0 = errors;
        repeat (6) run_frame(rand_range(60, 200), 1'b0, -1);
        wait_drain();
        report_test("random frames", e0);

        e0 = errors;
        repeat (6) run_frame(rand_range(1, 59), 1'b0, -1);
        wait_drain();
        report_test("short frames padded", e0);

        e0 = errors;
        repeat (3) begin
            run_frame(rand_range(64, 200), 1'b1, -1);
            run_frame(rand_range(60, 200), 1'b0, -1);
        end
        wait_drain();
        report_test("tuser error", e0);

        e0 = errors;
        repeat (3) begin
            len = rand_range(120, 200);
            run_frame(len, 1'b0, 8 + rand_bits(16) % ((len + 7) / 8 - 8));
            run_frame(rand_range(60, 200), 1'b0, -1);
        end
        wait_drain();
        report_test("underflow", e0);

        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            cfg_tx_ifg = 8'(rand_bits(8));
            run_frame(rand_range(60, 100), 1'b0, -1);
            run_frame(rand_range(60, 100), 1'b0, -1);
            wait_drain();
        end
        report_test("interframe gap", e0);

        e0 = errors;
        disabled_check();
        report_test("transmit disabled", e0);

        repeat (4) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
+incdir+verification
logic/xgmii_tx_pkg.sv
logic/xgmii_tx_ctrl.sv
logic/tx_beat_stage.sv
logic/eth_crc32.sv
logic/xgmii_encode.sv
logic/xgmii_tx.sv
verification/xgmii_tx_tb.sv
